//--- hdl/pong_pkg.sv
package pong_pkg;

    localparam int X_STEP       = 10;
    localparam int SERVE_Y      = 220;
    localparam int SERVE_VY     = -3;
    localparam int X_EDGE_LOW   = 300;  // Send edge, 320 wide screen
    localparam int X_EDGE_HIGH  = 620;  // Send edge, 640 wide screen
    localparam int Y_MAX_LOW    = 239;
    localparam int Y_MAX_HIGH   = 479;

    localparam int STEP_BASE    = 2700; // Cycles per step at speed 1
    localparam int STEP_SLOW    = 2700;
    localparam int STEP_FAST    = 1350;
    localparam int PERIOD_W     = 12;   // Holds STEP_BASE

    localparam int PADDLE_X     = 10;
    localparam int PADDLE_HALF  = 24;
    localparam int SPEED_WINDOW = 4096;
    localparam int MIN_SPEED    = 1;

    // One-hot state codes, exported as the status byte
    localparam logic [7:0] ST_IDLE     = 8'b0000_0001;
    localparam logic [7:0] ST_WAIT     = 8'b0000_0010;
    localparam logic [7:0] ST_WIN_FLAG = 8'b0000_0100;
    localparam logic [7:0] ST_STOP     = 8'b0001_0000;
    localparam logic [7:0] ST_SEND     = 8'b0010_0000;
    localparam logic [7:0] ST_LEFT     = 8'b0100_0000;
    localparam logic [7:0] ST_RIGHT    = 8'b1000_0000;

    typedef struct packed {
        logic [9:0]        x;
        logic [9:0]        y;
        logic signed [7:0] vy;            // Pixels per step
        logic [1:0]        gravity_phase;
        logic              fast;
    } ball_state_t;

    localparam ball_state_t SERVE_BALL = '{
        x:             10'd0,
        y:             10'(SERVE_Y),
        vy:            8'(SERVE_VY),
        gravity_phase: 2'd0,
        fast:          1'b0
    };

    typedef struct packed {
        logic [7:0] y_hi;       // Bits 7:6 are y[9:8]
        logic [7:0] y_lo;
        logic [7:0] vy;
        logic [7:0] gravity;    // Bits 1:0 are the phase
        logic [7:0] speed_flag; // Bit 0 set means slow
        logic [7:0] win_flag;   // Bit 0 set means receiver wins
    } link_fields_t;

    typedef union packed {
        logic [0:5][7:0] regs;  // regs[0] is y_hi
        link_fields_t    fields;
    } link_frame_u;

endpackage

//--- hdl/ball_motion.sv
`timescale 1ns/1ns

module ball_motion
    import pong_pkg::*;
(
    input  logic        clk_25MHZ,
    input  logic        reset,
    input  logic        upscale,
    input  logic        step_tick,
    input  logic        moving_left,
    input  logic        load,
    input  ball_state_t load_state,
    output ball_state_t ball
);

    logic [9:0]         y_max;
    logic signed [11:0] y_sum;
    logic signed [7:0]  vy_grav;
    ball_state_t        ball_step;

    assign y_max = upscale ? 10'(Y_MAX_HIGH) : 10'(Y_MAX_LOW);

    always_comb begin
        ball_step = ball;

        if (moving_left) begin
            ball_step.x = (ball.x > 10'(X_STEP)) ? ball.x - 10'(X_STEP) : 10'd0;
        end else begin
            ball_step.x = ball.x + 10'(X_STEP);
        end

        y_sum = $signed({2'b00, ball.y}) + $signed({{4{ball.vy[7]}}, ball.vy}); // Old vy

        ball_step.gravity_phase = ball.gravity_phase + 2'd1;
        vy_grav = (ball.gravity_phase == 2'd3) ? ball.vy + 8'sd1 : ball.vy; // Wrap to 0

        if (y_sum >= $signed({2'b00, y_max})) begin
            ball_step.y  = y_max;   // Floor bounce
            ball_step.vy = -vy_grav;
        end else if (y_sum <= 12'sd0) begin
            ball_step.y  = 10'd0;   // Ceiling bounce
            ball_step.vy = -vy_grav;
        end else begin
            ball_step.y  = y_sum[9:0];
            ball_step.vy = vy_grav;
        end
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            ball <= SERVE_BALL;
        end else if (load) begin
            ball <= load_state;
        end else if (step_tick) begin
            ball <= ball_step;
        end
    end

    // Ball stays on screen for the chosen floor
    assert property (@(posedge clk_25MHZ) disable iff (reset)
        ball.y <= y_max);

endmodule

//--- hdl/rally_controller.sv
`timescale 1ns/1ns

module rally_controller
    import pong_pkg::*;
(
    input  logic        clk_25MHZ,
    input  logic        reset,
    input  logic        upscale,
    input  logic        game_start,
    input  logic        hit,
    input  logic [9:0]  speed,
    input  ball_state_t ball,
    input  ball_state_t rx_ball,
    input  logic        rx_win,
    input  logic        slave_done,
    input  logic        master_done,
    output logic        step_tick,
    output logic        moving_left,
    output logic        moving_right,
    output logic        load,
    output ball_state_t load_state,
    output logic        send_trigger,
    output logic        responding,
    output logic        game_over,
    output logic        is_you_win,
    output logic [7:0]  status
);

    logic [7:0]          state, state_next;
    logic [PERIOD_W-1:0] count, count_next;
    logic [PERIOD_W-1:0] period, period_next;
    logic [PERIOD_W-1:0] hit_period, rx_period;
    logic [9:0]          safe_speed;
    logic [9:0]          x_edge;
    logic                win_next;
    logic                count_done;
    ball_state_t         rx_load;

    assign moving_left  = (state == ST_LEFT);
    assign moving_right = (state == ST_RIGHT);
    assign send_trigger = (state == ST_SEND);
    assign responding   = (state == ST_WAIT);
    assign game_over    = (state == ST_STOP);
    assign status       = state;

    assign x_edge     = upscale ? 10'(X_EDGE_HIGH) : 10'(X_EDGE_LOW);
    assign count_done = (count >= period);
    assign safe_speed = (speed < 10'(MIN_SPEED)) ? 10'(MIN_SPEED) : speed;
    assign hit_period = PERIOD_W'(STEP_BASE / safe_speed);
    assign rx_period  = rx_ball.fast ? PERIOD_W'(STEP_FAST) : PERIOD_W'(STEP_SLOW);

    always_comb begin
        rx_load = rx_ball;
        if (!upscale) begin
            rx_load.x = 10'(X_EDGE_LOW); // Enter at this screen's edge
        end
    end

    always_comb begin
        state_next  = state;
        period_next = period;
        win_next    = is_you_win;
        step_tick   = 1'b0;
        load        = 1'b0;
        load_state  = SERVE_BALL;

        case (state)
            ST_IDLE: begin
                if (slave_done) begin
                    load        = 1'b1;
                    load_state  = rx_load;
                    period_next = rx_period;
                    win_next    = rx_win;
                    state_next  = ST_WAIT;
                end else if (game_start) begin
                    load        = 1'b1;
                    period_next = PERIOD_W'(STEP_BASE);
                    win_next    = 1'b0;
                    state_next  = ST_RIGHT;
                end
            end
            ST_RIGHT: begin
                if (ball.x >= x_edge) begin
                    state_next = ST_SEND;
                end else begin
                    step_tick = count_done;
                end
            end
            ST_LEFT: begin
                if (hit) begin
                    load            = 1'b1;
                    load_state      = ball;
                    load_state.fast = (hit_period <= PERIOD_W'(STEP_FAST));
                    period_next     = hit_period;
                    state_next      = ST_RIGHT;
                end else if (ball.x == 10'd0) begin
                    state_next = ST_STOP; // Missed
                end else begin
                    step_tick = count_done;
                end
            end
            ST_STOP: begin
                if (game_start) begin
                    load        = 1'b1;
                    period_next = PERIOD_W'(STEP_BASE);
                    state_next  = ST_RIGHT;
                end
            end
            ST_SEND: begin
                if (game_start) begin
                    state_next = ST_IDLE;
                end else if (master_done) begin
                    state_next = ST_WIN_FLAG;
                end
            end
            ST_WIN_FLAG: begin
                if (game_start) begin
                    state_next = ST_IDLE;
                end else if (slave_done && !master_done) begin
                    load        = 1'b1;
                    load_state  = rx_load;
                    period_next = rx_period;
                    win_next    = rx_win;
                    state_next  = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (!slave_done) begin
                    state_next = is_you_win ? ST_IDLE : ST_LEFT;
                end
            end
            default: state_next = ST_IDLE;
        endcase

        if (state_next != state || !(moving_left || moving_right) || count_done) begin
            count_next = '0;
        end else begin
            count_next = count + 1'b1;
        end
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state      <= ST_IDLE;
            count      <= '0;
            period     <= PERIOD_W'(STEP_SLOW);
            is_you_win <= 1'b0;
        end else begin
            state      <= state_next;
            count      <= count_next;
            period     <= period_next;
            is_you_win <= win_next;
        end
    end

    assert property (@(posedge clk_25MHZ) disable iff (reset)
        !(moving_left && moving_right));

endmodule

//--- hdl/paddle_collision.sv
`timescale 1ns/1ns

module paddle_collision
    import pong_pkg::*;
(
    input  ball_state_t ball,
    input  logic [9:0]  paddle_y,
    input  logic        moving_left,
    output logic        hit
);

    logic [9:0] y_dist;
    logic       in_column;
    logic       in_height;

    assign y_dist = (ball.y >= paddle_y) ? ball.y - paddle_y : paddle_y - ball.y;

    assign in_column = (ball.x <= 10'(PADDLE_X));
    assign in_height = (y_dist <= 10'(PADDLE_HALF)); // Within half height either side

    assign hit = moving_left && in_column && in_height;

endmodule

//--- hdl/swing_speed_estimator.sv
`timescale 1ns/1ns

module swing_speed_estimator
    import pong_pkg::*;
(
    input  logic       clk_25MHZ,
    input  logic       reset,
    input  logic [9:0] paddle_y,
    output logic [9:0] speed
);

    logic [$clog2(SPEED_WINDOW)-1:0] window_cnt;
    logic [9:0]                      prev_y;
    logic [9:0]                      travel;

    assign travel = (paddle_y >= prev_y) ? paddle_y - prev_y : prev_y - paddle_y;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            window_cnt <= '0;
            prev_y     <= '0;
            speed      <= '0;
        end else begin
            window_cnt <= window_cnt + 1'b1; // Wraps every window
            if (window_cnt == $bits(window_cnt)'(SPEED_WINDOW - 1)) begin
                prev_y <= paddle_y;
                speed  <= travel >> 3;
            end
        end
    end

endmodule

//--- hdl/ball_link_regs.sv
`timescale 1ns/1ns

module ball_link_regs
    import pong_pkg::*;
(
    input  logic        clk_25MHZ,
    input  logic        reset,
    input  logic        send_trigger,
    input  ball_state_t ball,
    input  logic        is_you_win,
    input  link_frame_u rx_frame,
    output link_frame_u tx_frame,
    output ball_state_t rx_ball,
    output logic        rx_win
);

    logic        send_q;
    link_frame_u tx_next;

    always_comb begin
        tx_next.fields.y_hi       = {ball.y[9:8], 6'd0};
        tx_next.fields.y_lo       = ball.y[7:0];
        tx_next.fields.vy         = ball.vy;
        tx_next.fields.gravity    = {6'd0, ball.gravity_phase};
        tx_next.fields.speed_flag = {7'd0, !ball.fast};
        tx_next.fields.win_flag   = 8'd0;
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            send_q   <= 1'b0;
            tx_frame <= '0;
        end else begin
            send_q <= send_trigger;
            if (is_you_win) begin
                tx_frame <= '0;       // Game over, drop last frame
            end else if (send_trigger && !send_q) begin
                tx_frame <= tx_next;
            end
        end
    end

    always_comb begin
        rx_ball.x             = 10'(X_EDGE_HIGH); // Frame carries no x
        rx_ball.y             = {rx_frame.fields.y_hi[7:6], rx_frame.fields.y_lo};
        rx_ball.vy            = rx_frame.fields.vy;
        rx_ball.gravity_phase = rx_frame.fields.gravity[1:0];
        rx_ball.fast          = !rx_frame.fields.speed_flag[0];
    end

    assign rx_win = rx_frame.regs[5][0]; // Win register

endmodule

//--- hdl/two_board_pong_top.sv
`timescale 1ns/1ns

module two_board_pong_top
    import pong_pkg::*;
(
    input  logic        clk_25MHZ,
    input  logic        reset,
    input  logic        upscale,
    input  logic [9:0]  paddle_y,
    input  logic        game_start,
    input  logic        master_done,
    input  logic        slave_done,
    input  link_frame_u rx_frame,
    output logic        send_trigger,
    output link_frame_u tx_frame,
    output logic        responding,
    output ball_state_t ball,
    output logic        game_over,
    output logic        is_you_win,
    output logic [7:0]  status
);

    logic        step_tick;
    logic        moving_left;
    logic        load;
    logic        hit;
    logic        rx_win;
    logic [9:0]  speed;
    ball_state_t load_state;
    ball_state_t rx_ball;

    rally_controller u_ctrl (
        .clk_25MHZ    (clk_25MHZ),
        .reset        (reset),
        .upscale      (upscale),
        .game_start   (game_start),
        .hit          (hit),
        .speed        (speed),
        .ball         (ball),
        .rx_ball      (rx_ball),
        .rx_win       (rx_win),
        .slave_done   (slave_done),
        .master_done  (master_done),
        .step_tick    (step_tick),
        .moving_left  (moving_left),
        .moving_right (),
        .load         (load),
        .load_state   (load_state),
        .send_trigger (send_trigger),
        .responding   (responding),
        .game_over    (game_over),
        .is_you_win   (is_you_win),
        .status       (status)
    );

    ball_motion u_motion (
        .clk_25MHZ   (clk_25MHZ),
        .reset       (reset),
        .upscale     (upscale),
        .step_tick   (step_tick),
        .moving_left (moving_left),
        .load        (load),
        .load_state  (load_state),
        .ball        (ball)
    );

    paddle_collision u_collision (
        .ball        (ball),
        .paddle_y    (paddle_y),
        .moving_left (moving_left),
        .hit         (hit)
    );

    swing_speed_estimator u_speed (
        .clk_25MHZ (clk_25MHZ),
        .reset     (reset),
        .paddle_y  (paddle_y),
        .speed     (speed)
    );

    ball_link_regs u_link (
        .clk_25MHZ    (clk_25MHZ),
        .reset        (reset),
        .send_trigger (send_trigger),
        .ball         (ball),
        .is_you_win   (is_you_win),
        .rx_frame     (rx_frame),
        .tx_frame     (tx_frame),
        .rx_ball      (rx_ball),
        .rx_win       (rx_win)
    );

endmodule

//--- testbench/tb_two_board_pong.sv
`timescale 1ns/1ns

module tb_two_board_pong
    import pong_pkg::*;
();

    logic        clk_25MHZ;
    logic        reset;
    logic        upscale;
    logic [9:0]  paddle_y;
    logic        game_start;
    logic        master_done;
    logic        slave_done;
    link_frame_u rx_frame;
    logic        send_trigger;
    link_frame_u tx_frame;
    logic        responding;
    ball_state_t ball;
    logic        game_over;
    logic        is_you_win;
    logic [7:0]  status;

    ball_state_t model;     // Expected ball
    int          mismatches;
    int          timeouts;

    two_board_pong_top dut (
        .clk_25MHZ    (clk_25MHZ),
        .reset        (reset),
        .upscale      (upscale),
        .paddle_y     (paddle_y),
        .game_start   (game_start),
        .master_done  (master_done),
        .slave_done   (slave_done),
        .rx_frame     (rx_frame),
        .send_trigger (send_trigger),
        .tx_frame     (tx_frame),
        .responding   (responding),
        .ball         (ball),
        .game_over    (game_over),
        .is_you_win   (is_you_win),
        .status       (status)
    );

    initial begin
        clk_25MHZ = 1'b0;
        forever #20 clk_25MHZ = ~clk_25MHZ;
    end

    function automatic ball_state_t serve_state();
        ball_state_t b;
        b.x             = 10'd0;
        b.y             = 10'(SERVE_Y);
        b.vy            = 8'(SERVE_VY);
        b.gravity_phase = 2'd0;
        b.fast          = 1'b0;
        return b;
    endfunction

    // Ball as it should appear after a frame is received
    function automatic ball_state_t received_state(input logic [9:0] y,
                                                   input logic signed [7:0] vy,
                                                   input logic [1:0] phase,
                                                   input logic slow);
        ball_state_t b;
        b.x             = 10'(X_EDGE_LOW);
        b.y             = y;
        b.vy            = vy;
        b.gravity_phase = phase;
        b.fast          = !slow;
        return b;
    endfunction

    function automatic link_frame_u make_frame(input logic [9:0] y,
                                               input logic signed [7:0] vy,
                                               input logic [1:0] phase,
                                               input logic slow,
                                               input logic win);
        link_frame_u f;
        f.fields.y_hi       = {y[9:8], 6'd0};
        f.fields.y_lo       = y[7:0];
        f.fields.vy         = vy;
        f.fields.gravity    = {6'd0, phase};
        f.fields.speed_flag = {7'd0, slow};
        f.fields.win_flag   = {7'd0, win};
        return f;
    endfunction

    // One step of motion, gravity and bounce
    function automatic ball_state_t model_step(input ball_state_t b, input logic left);
        ball_state_t n;
        int          y_new;
        int          vy_new;
        int          floor_y;
        n = b;
        if (left) begin
            n.x = (b.x > 10'(X_STEP)) ? b.x - 10'(X_STEP) : 10'd0;
        end else begin
            n.x = b.x + 10'(X_STEP);
        end
        y_new           = int'(b.y) + int'(b.vy);
        vy_new          = int'(b.vy) + ((b.gravity_phase == 2'd3) ? 1 : 0);
        n.gravity_phase = b.gravity_phase + 2'd1;
        floor_y         = upscale ? Y_MAX_HIGH : Y_MAX_LOW;
        if (y_new >= floor_y) begin
            n.y    = 10'(floor_y);
            vy_new = -vy_new;
        end else if (y_new <= 0) begin
            n.y    = 10'd0;
            vy_new = -vy_new;
        end else begin
            n.y = 10'(y_new);
        end
        n.vy = 8'(vy_new);
        return n;
    endfunction

    task automatic check_value(input string name, input logic [47:0] got,
                               input logic [47:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic wait_ball_change(input ball_state_t prev, input int limit);
        int n;
        n = 0;
        @(negedge clk_25MHZ);
        while (ball == prev && n < limit) begin
            @(negedge clk_25MHZ);
            n++;
        end
        if (ball == prev) begin
            timeouts++;
            $display("Timeout at %0t ns: ball did not move within %0d cycles", $time, limit);
        end
    endtask

    task automatic wait_state(input logic [7:0] code, input int limit);
        int n;
        n = 0;
        @(negedge clk_25MHZ);
        while (status != code && n < limit) begin
            @(negedge clk_25MHZ);
            n++;
        end
        if (status != code) begin
            timeouts++;
            $display("Timeout at %0t ns: state %h never reached, still %h", $time, code, status);
        end
    endtask

    task automatic follow_steps(input logic left, input int steps);
        ball_state_t prev;
        for (int i = 0; i < steps; i++) begin
            prev = ball;
            wait_ball_change(prev, 3000);
            model = model_step(model, left);
            check_value("ball", 48'(ball), 48'(model));
        end
    endtask

    task automatic pulse_game_start();
        @(negedge clk_25MHZ);
        game_start = 1'b1;
        @(negedge clk_25MHZ);
        game_start = 1'b0;
    endtask

    // Master finishes, then the other board's frame arrives after a delay
    task automatic exchange_frame(input link_frame_u frame, input int latency);
        master_done = 1'b1;
        wait_state(ST_WIN_FLAG, 10);
        check_value("send_trigger", 48'(send_trigger), 48'd0);
        master_done = 1'b0;
        rx_frame    = frame;
        slave_done  = 1'b1;
        wait_state(ST_WAIT, 10);
        check_value("responding", 48'(responding), 48'd1);
        repeat (latency) @(negedge clk_25MHZ);
        slave_done = 1'b0;
    endtask

    task automatic test_reset_state();
        check_value("status", 48'(status), 48'(ST_IDLE));
        check_value("ball", 48'(ball), 48'(serve_state()));
        check_value("send_trigger", 48'(send_trigger), 48'd0);
        check_value("game_over", 48'(game_over), 48'd0);
        check_value("is_you_win", 48'(is_you_win), 48'd0);
        check_value("responding", 48'(responding), 48'd0);
    endtask

    task automatic test_serve_flight();
        pulse_game_start();
        model = serve_state();
        check_value("ball", 48'(ball), 48'(model));
        follow_steps(1'b0, (X_EDGE_LOW - int'(model.x)) / X_STEP);
        wait_state(ST_SEND, 10);
        check_value("send_trigger", 48'(send_trigger), 48'd1);
        @(negedge clk_25MHZ); // Frame lands one cycle later
        check_value("tx_frame.y", 48'({tx_frame.fields.y_hi[7:6], tx_frame.fields.y_lo}),
                    48'(model.y));
        check_value("tx_frame.vy", 48'(tx_frame.fields.vy), 48'($unsigned(model.vy)));
        check_value("tx_frame.gravity", 48'(tx_frame.fields.gravity[1:0]),
                    48'(model.gravity_phase));
        check_value("tx_frame.speed_flag", 48'(tx_frame.fields.speed_flag[0]),
                    48'(!model.fast));
        check_value("tx_frame.win_flag", 48'(tx_frame.fields.win_flag), 48'd0);
    endtask

    task automatic test_handoff_receive();
        exchange_frame(make_frame(10'd150, -8'sd2, 2'd1, 1'b1, 1'b0), 7);
        wait_state(ST_LEFT, 10);
        check_value("responding", 48'(responding), 48'd0);
        model = received_state(10'd150, -8'sd2, 2'd1, 1'b1);
        check_value("ball", 48'(ball), 48'(model));
        follow_steps(1'b1, 5);
    endtask

    task automatic test_return_hit();
        ball_state_t ahead;
        ahead = model;
        while (ahead.x > 10'(PADDLE_X)) begin
            ahead = model_step(ahead, 1'b1);
        end
        paddle_y = ahead.y; // Paddle waits where the ball arrives
        follow_steps(1'b1, (int'(model.x) - PADDLE_X) / X_STEP);
        check_value("ball.x at paddle", 48'(ball.x <= 10'(PADDLE_X)), 48'd1);
        follow_steps(1'b0, 1);
        check_value("status", 48'(status), 48'(ST_RIGHT));
        check_value("game_over", 48'(game_over), 48'd0);
        follow_steps(1'b0, (X_EDGE_LOW - int'(model.x)) / X_STEP);
        wait_state(ST_SEND, 10);
    endtask

    task automatic test_miss();
        paddle_y = 10'd600; // Out of reach of any y
        exchange_frame(make_frame(10'd100, 8'sd3, 2'd2, 1'b0, 1'b0), 3);
        wait_state(ST_LEFT, 10);
        model = received_state(10'd100, 8'sd3, 2'd2, 1'b0);
        check_value("ball", 48'(ball), 48'(model));
        follow_steps(1'b1, int'(model.x) / X_STEP);
        wait_state(ST_STOP, 10);
        check_value("game_over", 48'(game_over), 48'd1);
        pulse_game_start();
        model = serve_state();
        check_value("ball", 48'(ball), 48'(model));
        follow_steps(1'b0, 1);
        check_value("game_over", 48'(game_over), 48'd0);
    endtask

    task automatic test_win_frame();
        ball_state_t held;
        follow_steps(1'b0, (X_EDGE_LOW - int'(model.x)) / X_STEP);
        wait_state(ST_SEND, 10);
        exchange_frame(make_frame(10'd50, 8'sd1, 2'd0, 1'b1, 1'b1), 5);
        check_value("is_you_win", 48'(is_you_win), 48'd1);
        wait_state(ST_IDLE, 10);
        held = ball;
        repeat (3000) @(negedge clk_25MHZ); // Longer than a slow step
        check_value("ball", 48'(ball), 48'(held));
        check_value("status", 48'(status), 48'(ST_IDLE));
        check_value("is_you_win", 48'(is_you_win), 48'd1);
    endtask

    initial begin
        mismatches  = 0;
        timeouts    = 0;
        reset       = 1'b1;
        upscale     = 1'b0;
        paddle_y    = 10'd0;
        game_start  = 1'b0;
        master_done = 1'b0;
        slave_done  = 1'b0;
        rx_frame    = '0;
        model       = serve_state();
        repeat (5) @(negedge clk_25MHZ);
        reset = 1'b0;

        test_reset_state();
        test_serve_flight();
        test_handoff_receive();
        test_return_hit();
        test_miss();
        test_win_frame();

        $display("Error count: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- two_board_pong.f
hdl/pong_pkg.sv
hdl/ball_motion.sv
hdl/rally_controller.sv
hdl/paddle_collision.sv
hdl/swing_speed_estimator.sv
hdl/ball_link_regs.sv
hdl/two_board_pong_top.sv
testbench/tb_two_board_pong.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_two_board_pong -f two_board_pong.f \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/Vtb_two_board_pong)
echo "$out"
echo "$out" | grep -qx "All checks passed" && echo "PASS" || { echo "FAIL"; exit 1; }
